/* jsp_pkg.sv */
// JTAG serial port constants: UART register map, FIFO sizing and FSM encodings
package jsp_pkg;

  ////////////////////////////////////////////////////////////
  // FIFO sizing
  ////////////////////////////////////////////////////////////

  // Bytes per FIFO
  localparam int FIFO_DEPTH = 8;
  // Occupancy count width, holds 0 to FIFO_DEPTH
  localparam int CNT_W = 4;

  ////////////////////////////////////////////////////////////
  // 16550-style register offsets
  ////////////////////////////////////////////////////////////

  localparam logic [2:0] ADDR_RBR_THR = 3'd0;
  localparam logic [2:0] ADDR_IER     = 3'd1;
  localparam logic [2:0] ADDR_IIR_FCR = 3'd2;
  localparam logic [2:0] ADDR_LCR     = 3'd3;
  localparam logic [2:0] ADDR_MCR     = 3'd4;
  localparam logic [2:0] ADDR_LSR     = 3'd5;
  localparam logic [2:0] ADDR_MSR     = 3'd6;
  localparam logic [2:0] ADDR_SCR     = 3'd7;

  // Divisor latch access, turns offsets 0 and 1 into plain registers
  localparam int LCR_DLAB_BIT = 7;

  // FCR flush bits
  localparam int FCR_RX_RST_BIT = 1;
  localparam int FCR_TX_RST_BIT = 2;

  // IIR codes, highest priority last
  localparam logic [7:0] IIR_NONE = 8'h01;
  localparam logic [7:0] IIR_THRE = 8'h02;
  localparam logic [7:0] IIR_RDA  = 8'h04;

  // Fixed modem status
  localparam logic [7:0] MSR_VALUE = 8'h0B;

  ////////////////////////////////////////////////////////////
  // FSM encodings
  ////////////////////////////////////////////////////////////

  // Debug-to-APB path
  typedef enum logic [1:0] {RX_IDLE, RX_PUSH, RX_HOLD} rx_state_e;

  // APB-to-debug path
  typedef enum logic [1:0] {TX_IDLE, TX_PUSH, TX_POP, TX_LATCH} tx_state_e;

endpackage

/* jsp_fifo_if.sv */
// Push/pop port and status of one byte FIFO, shared by control and registers
`timescale 1ns/100ps

interface jsp_fifo_if;

  // Request side
  logic                     push_o;
  logic                     pop_o;
  logic [7:0]               wdata_o;
  // Status side, rdata is the head or 0 when empty
  logic [7:0]               rdata;
  logic [jsp_pkg::CNT_W-1:0] count;
  logic                     full;
  logic                     empty;
  // Synchronous clear from the FCR
  logic                     flush;

  // FIFO state machines
  modport ctrl (output push_o, pop_o, wdata_o, input rdata, empty);

  // Storage
  modport fifo (input push_o, pop_o, wdata_o, flush, output rdata, count, full, empty);

  // Register file, reads the head for RBR and watches drains for THRE
  modport regs (output flush, input rdata, count, full, empty, pop_o);

endinterface

/* jsp_byte_fifo.sv */
// Eight-entry byte FIFO with occupancy counter and synchronous flush
`timescale 1ns/100ps

module jsp_byte_fifo (
  input  logic PCLK,
  input  logic PRESETn,
  jsp_fifo_if.fifo f
);

  ////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////

  logic [7:0]                                 mem [jsp_pkg::FIFO_DEPTH];
  logic [$clog2(jsp_pkg::FIFO_DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(jsp_pkg::FIFO_DEPTH)-1:0]     rd_ptr_q;
  logic [jsp_pkg::CNT_W-1:0]                  count_q;
  logic                                       do_push;
  logic                                       do_pop;

  // Overflow and underflow requests are dropped
  assign do_push = f.push_o & ~f.full;
  assign do_pop  = f.pop_o & ~f.empty;

  // Data array, no reset
  always_ff @(posedge PCLK) begin
    if (do_push) begin
      mem[wr_ptr_q] <= f.wdata_o;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (f.flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Status decoded from the count
  assign f.count = count_q;
  assign f.empty = (count_q == '0);
  assign f.full  = (count_q == jsp_pkg::CNT_W'(jsp_pkg::FIFO_DEPTH));
  // Head byte, forced to zero when nothing is stored
  assign f.rdata = f.empty ? 8'h00 : mem[rd_ptr_q];

endmodule

/* jsp_toggle_sync.sv */
// Debug strobe to PCLK event crossing with byte capture and sticky flag
`timescale 1ns/100ps

module jsp_toggle_sync (
  input  logic       tck_i,
  input  logic       PCLK,
  input  logic       PRESETn,
  input  logic       strobe_i,
  input  logic [7:0] data_i,
  input  logic       clr_i,
  output logic       event_o,
  output logic [7:0] data_o
);

  logic       tog_q;
  logic [7:0] data_q;
  logic       sync1_q;
  logic       sync2_q;
  logic       sync3_q;
  logic       event_q;

  ////////////////////////////////////////////////////////////
  // tck side
  ////////////////////////////////////////////////////////////

  // Each strobe flips the toggle and grabs the byte
  always_ff @(posedge tck_i or negedge PRESETn) begin
    if (!PRESETn) begin
      tog_q  <= 1'b0;
      data_q <= 8'h00;
    end else if (strobe_i) begin
      tog_q  <= ~tog_q;
      data_q <= data_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // PCLK side
  ////////////////////////////////////////////////////////////

  // Two flops to resolve metastability, third one for edge detect
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      sync3_q <= 1'b0;
    end else begin
      sync1_q <= tog_q;
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
    end
  end

  // Sticky flag, a fresh edge wins over the clear
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      event_q <= 1'b0;
    end else if (sync2_q ^ sync3_q) begin
      event_q <= 1'b1;
    end else if (clr_i) begin
      event_q <= 1'b0;
    end
  end

  assign event_o = event_q;
  // Captured long before the flag rises, so quiet while it is high
  assign data_o  = data_q;

endmodule

/* jsp_count_sync.sv */
// PCLK to tck transfer of a FIFO count by request and acknowledge toggles
`timescale 1ns/100ps

module jsp_count_sync (
  input  logic                      PCLK,
  input  logic                      tck_i,
  input  logic                      PRESETn,
  input  logic [jsp_pkg::CNT_W-1:0] count_i,
  output logic [jsp_pkg::CNT_W-1:0] count_o
);

  logic [jsp_pkg::CNT_W-1:0] hold_q;
  logic                      req_q;
  logic                      ack_s1_q;
  logic                      ack_s2_q;
  logic                      req_s1_q;
  logic                      req_s2_q;
  logic                      ack_q;

  ////////////////////////////////////////////////////////////
  // PCLK side
  ////////////////////////////////////////////////////////////

  // New sample only once the previous one has been acknowledged
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      req_q    <= 1'b0;
      ack_s1_q <= 1'b0;
      ack_s2_q <= 1'b0;
    end else begin
      ack_s1_q <= ack_q;
      ack_s2_q <= ack_s1_q;
      if (ack_s2_q == req_q) begin
        req_q <= ~req_q;
      end
    end
  end

  // Holding register stays put while a request is in flight
  always_ff @(posedge PCLK) begin
    if (ack_s2_q == req_q) begin
      hold_q <= count_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // tck side
  ////////////////////////////////////////////////////////////

  // Load on a request edge, ack follows the synchronized request
  always_ff @(posedge tck_i or negedge PRESETn) begin
    if (!PRESETn) begin
      req_s1_q <= 1'b0;
      req_s2_q <= 1'b0;
      ack_q    <= 1'b0;
      count_o  <= '0;
    end else begin
      req_s1_q <= req_q;
      req_s2_q <= req_s1_q;
      ack_q    <= req_s2_q;
      if (req_s2_q != ack_q) begin
        count_o <= hold_q;
      end
    end
  end

endmodule

/* jsp_fifo_ctrl.sv */
// State machines moving bytes between the debug events, the APB and both FIFOs
`timescale 1ns/100ps

module jsp_fifo_ctrl (
  input  logic       PCLK,
  input  logic       PRESETn,
  // Debug events, already in PCLK
  input  logic       wr_event_i,
  input  logic [7:0] wr_data_i,
  input  logic       rd_event_i,
  output logic       wr_clr_o,
  output logic       rd_clr_o,
  // APB FIFO requests from the setup phase
  input  logic       fifo_rd_req_i,
  input  logic       fifo_wr_req_i,
  input  logic [7:0] pwdata_i,
  output logic       fifo_ack_o,
  // Head of the tx FIFO towards the debug side
  output logic [7:0] data_o,
  jsp_fifo_if.ctrl   rx,
  jsp_fifo_if.ctrl   tx
);

  jsp_pkg::rx_state_e rx_state_q;
  jsp_pkg::rx_state_e rx_state_d;
  jsp_pkg::tx_state_e tx_state_q;
  jsp_pkg::tx_state_e tx_state_d;
  logic               rd_pend_q;
  logic               wr_pend_q;
  logic               rd_req;
  logic               wr_req;
  logic               tx_rd_ok;

  ////////////////////////////////////////////////////////////
  // Pending APB requests
  ////////////////////////////////////////////////////////////

  // Held until served so a busy machine never loses one
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
    end else begin
      if (rx_state_q == jsp_pkg::RX_HOLD) begin
        rd_pend_q <= 1'b0;
      end else if (fifo_rd_req_i) begin
        rd_pend_q <= 1'b1;
      end
      if (tx_state_q == jsp_pkg::TX_PUSH) begin
        wr_pend_q <= 1'b0;
      end else if (fifo_wr_req_i) begin
        wr_pend_q <= 1'b1;
      end
    end
  end

  // Live setup pulse or a latched one
  assign rd_req   = fifo_rd_req_i | rd_pend_q;
  assign wr_req   = fifo_wr_req_i | wr_pend_q;
  // Debug read waits until there is something to hand over
  assign tx_rd_ok = rd_event_i & ~tx.empty;

  ////////////////////////////////////////////////////////////
  // rx machine, debug writes in and APB reads out
  ////////////////////////////////////////////////////////////

  always_comb begin
    rx_state_d = jsp_pkg::RX_IDLE;
    case (rx_state_q)
      jsp_pkg::RX_IDLE: begin
        // APB read first, then the debug byte
        if (rd_req) begin
          rx_state_d = jsp_pkg::RX_HOLD;
        end else if (wr_event_i) begin
          rx_state_d = jsp_pkg::RX_PUSH;
        end
      end
      jsp_pkg::RX_PUSH: begin
        if (rd_req) begin
          rx_state_d = jsp_pkg::RX_HOLD;
        end
      end
      jsp_pkg::RX_HOLD: begin
        if (wr_event_i) begin
          rx_state_d = jsp_pkg::RX_PUSH;
        end
      end
      default: rx_state_d = jsp_pkg::RX_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // tx machine, APB writes in and debug reads out
  ////////////////////////////////////////////////////////////

  always_comb begin
    tx_state_d = jsp_pkg::TX_IDLE;
    case (tx_state_q)
      jsp_pkg::TX_IDLE, jsp_pkg::TX_LATCH: begin
        if (wr_req) begin
          tx_state_d = jsp_pkg::TX_PUSH;
        end else if (tx_rd_ok) begin
          tx_state_d = jsp_pkg::TX_POP;
        end
      end
      jsp_pkg::TX_PUSH: begin
        // First byte into an empty FIFO becomes the new head
        if (tx.empty) begin
          tx_state_d = jsp_pkg::TX_LATCH;
        end else if (tx_rd_ok) begin
          tx_state_d = jsp_pkg::TX_POP;
        end
      end
      jsp_pkg::TX_POP: tx_state_d = jsp_pkg::TX_LATCH;
      default: tx_state_d = jsp_pkg::TX_IDLE;
    endcase
  end

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      rx_state_q <= jsp_pkg::RX_IDLE;
      tx_state_q <= jsp_pkg::TX_IDLE;
      data_o     <= 8'h00;
    end else begin
      rx_state_q <= rx_state_d;
      tx_state_q <= tx_state_d;
      // Refresh the debug-side byte with the head after it moved
      if (tx_state_q == jsp_pkg::TX_LATCH) begin
        data_o <= tx.rdata;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // State outputs
  ////////////////////////////////////////////////////////////

  assign rx.push_o   = (rx_state_q == jsp_pkg::RX_PUSH);
  assign rx.pop_o    = (rx_state_q == jsp_pkg::RX_HOLD);
  assign rx.wdata_o  = wr_data_i;
  assign wr_clr_o    = (rx_state_q == jsp_pkg::RX_PUSH);

  assign tx.push_o   = (tx_state_q == jsp_pkg::TX_PUSH);
  assign tx.pop_o    = (tx_state_q == jsp_pkg::TX_POP);
  assign tx.wdata_o  = pwdata_i;
  assign rd_clr_o    = (tx_state_q == jsp_pkg::TX_POP);

  // RBR data sits on PRDATA during HOLD, THR data on PWDATA during PUSH
  assign fifo_ack_o  = (rx_state_q == jsp_pkg::RX_HOLD) | (tx_state_q == jsp_pkg::TX_PUSH);

endmodule

/* jsp_uart_regs.sv */
// 16550-style register file with FIFO request decode, IIR and interrupt
`timescale 1ns/100ps

module jsp_uart_regs (
  input  logic       PCLK,
  input  logic       PRESETn,
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  logic [2:0] paddr_i,
  input  logic [7:0] pwdata_i,
  input  logic       fifo_ack_i,
  output logic [7:0] prdata_o,
  output logic       pready_o,
  output logic       fifo_rd_req_o,
  output logic       fifo_wr_req_o,
  output logic       int_o,
  jsp_fifo_if.regs   rx,
  jsp_fifo_if.regs   tx
);

  logic [3:0] ier_q;
  logic [7:0] lcr_q;
  logic [7:0] scr_q;
  logic       reg_ack_q;
  logic       thr_arm_q;
  logic       fifo_sel;
  logic       setup;
  logic       wr_acc;
  logic       iir_read;
  logic       tx_drain;
  logic [7:0] iir;
  logic [7:0] lsr;

  ////////////////////////////////////////////////////////////
  // Access decode
  ////////////////////////////////////////////////////////////

  // Offset 0 reaches the FIFOs only with DLAB clear
  assign fifo_sel = (paddr_i == jsp_pkg::ADDR_RBR_THR) & ~lcr_q[jsp_pkg::LCR_DLAB_BIT];
  assign setup    = psel_i & ~penable_i;
  assign wr_acc   = psel_i & penable_i & pwrite_i;

  // FIFO requests go out in the setup phase
  assign fifo_rd_req_o = setup & ~pwrite_i & fifo_sel;
  assign fifo_wr_req_o = setup & pwrite_i & fifo_sel;

  // FCR flush strobes
  assign rx.flush = wr_acc & (paddr_i == jsp_pkg::ADDR_IIR_FCR) & pwdata_i[jsp_pkg::FCR_RX_RST_BIT];
  assign tx.flush = wr_acc & (paddr_i == jsp_pkg::ADDR_IIR_FCR) & pwdata_i[jsp_pkg::FCR_TX_RST_BIT];

  assign iir_read = psel_i & penable_i & ~pwrite_i & (paddr_i == jsp_pkg::ADDR_IIR_FCR);
  // Last byte leaving the tx FIFO
  assign tx_drain = tx.pop_o & (tx.count == jsp_pkg::CNT_W'(1));

  ////////////////////////////////////////////////////////////
  // Writable registers and acknowledge
  ////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      ier_q     <= 4'h0;
      lcr_q     <= 8'h00;
      scr_q     <= 8'h00;
      reg_ack_q <= 1'b0;
    end else begin
      // Zero wait states for everything but the FIFO port
      reg_ack_q <= setup & ~fifo_sel;
      if (wr_acc) begin
        case (paddr_i)
          jsp_pkg::ADDR_IER: begin
            if (!lcr_q[jsp_pkg::LCR_DLAB_BIT]) begin
              ier_q <= pwdata_i[3:0];
            end
          end
          jsp_pkg::ADDR_LCR: lcr_q <= pwdata_i;
          jsp_pkg::ADDR_SCR: scr_q <= pwdata_i;
          default: ;
        endcase
      end
    end
  end

  // THRE arm, so an IIR read can retire a transmit interrupt
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      thr_arm_q <= 1'b0;
    end else if (fifo_wr_req_o || tx_drain) begin
      thr_arm_q <= 1'b1;
    end else if (iir_read && rx.empty) begin
      thr_arm_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Status, read mux and interrupt
  ////////////////////////////////////////////////////////////

  // Received data outranks THR empty
  always_comb begin
    if (!rx.empty) begin
      iir = jsp_pkg::IIR_RDA;
    end else if (thr_arm_q && !tx.full) begin
      iir = jsp_pkg::IIR_THRE;
    end else begin
      iir = jsp_pkg::IIR_NONE;
    end
  end

  // THRE and TEMT both mean room in the tx FIFO
  assign lsr = {1'b0, ~tx.full, ~tx.full, 4'h0, ~rx.empty};

  always_comb begin
    case (paddr_i)
      jsp_pkg::ADDR_RBR_THR: prdata_o = rx.rdata;
      jsp_pkg::ADDR_IER:     prdata_o = {4'h0, ier_q};
      jsp_pkg::ADDR_IIR_FCR: prdata_o = iir;
      jsp_pkg::ADDR_LCR:     prdata_o = lcr_q;
      jsp_pkg::ADDR_LSR:     prdata_o = lsr;
      jsp_pkg::ADDR_MSR:     prdata_o = jsp_pkg::MSR_VALUE;
      jsp_pkg::ADDR_SCR:     prdata_o = scr_q;
      // MCR reads zero
      default:               prdata_o = 8'h00;
    endcase
  end

  assign pready_o = reg_ack_q | fifo_ack_i;
  assign int_o    = (~rx.empty & ier_q[0]) | (thr_arm_q & ~tx.full & ier_q[1]);

endmodule

/* jsp_apb_top.sv */
// JTAG serial port bridge top joining the debug strobes to an APB4 UART view
`timescale 1ns/100ps

module jsp_apb_top (
  // Clocks and reset
  input  logic                      tck_i,
  input  logic                      PCLK,
  input  logic                      PRESETn,
  // Debug transport side
  input  logic [7:0]                data_i,
  output logic [7:0]                data_o,
  input  logic                      wr_strobe_i,
  input  logic                      rd_strobe_i,
  output logic [jsp_pkg::CNT_W-1:0] bytes_free_o,
  output logic [jsp_pkg::CNT_W-1:0] bytes_available_o,
  // APB4 slave
  input  logic                      PSEL,
  input  logic                      PENABLE,
  input  logic                      PWRITE,
  input  logic [2:0]                PADDR,
  input  logic [7:0]                PWDATA,
  output logic [7:0]                PRDATA,
  output logic                      PREADY,
  output logic                      PSLVERR,
  output logic                      int_o
);

  logic                      wr_event;
  logic                      rd_event;
  logic                      wr_clr;
  logic                      rd_clr;
  logic [7:0]                wr_byte;
  logic                      fifo_rd_req;
  logic                      fifo_wr_req;
  logic                      fifo_ack;
  logic [jsp_pkg::CNT_W-1:0] rx_cnt_tck;

  // rx carries debug bytes to the APB, tx the other way
  jsp_fifo_if rx_if ();
  jsp_fifo_if tx_if ();

  ////////////////////////////////////////////////////////////
  // FIFOs
  ////////////////////////////////////////////////////////////

  jsp_byte_fifo u_rx_fifo (.PCLK(PCLK), .PRESETn(PRESETn), .f(rx_if.fifo));
  jsp_byte_fifo u_tx_fifo (.PCLK(PCLK), .PRESETn(PRESETn), .f(tx_if.fifo));

  ////////////////////////////////////////////////////////////
  // Clock domain crossings
  ////////////////////////////////////////////////////////////

  jsp_toggle_sync u_wr_sync (
    .tck_i   (tck_i),
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .strobe_i(wr_strobe_i),
    .data_i  (data_i),
    .clr_i   (wr_clr),
    .event_o (wr_event),
    .data_o  (wr_byte)
  );

  // Read strobes carry no payload
  jsp_toggle_sync u_rd_sync (
    .tck_i   (tck_i),
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .strobe_i(rd_strobe_i),
    .data_i  (8'h00),
    .clr_i   (rd_clr),
    .event_o (rd_event),
    .data_o  ()
  );

  // rx occupancy moves across, free space is taken on the tck side
  jsp_count_sync u_free_sync (
    .PCLK   (PCLK),
    .tck_i  (tck_i),
    .PRESETn(PRESETn),
    .count_i(rx_if.count),
    .count_o(rx_cnt_tck)
  );

  assign bytes_free_o = jsp_pkg::CNT_W'(jsp_pkg::FIFO_DEPTH) - rx_cnt_tck;

  jsp_count_sync u_avail_sync (
    .PCLK   (PCLK),
    .tck_i  (tck_i),
    .PRESETn(PRESETn),
    .count_i(tx_if.count),
    .count_o(bytes_available_o)
  );

  ////////////////////////////////////////////////////////////
  // Control and registers
  ////////////////////////////////////////////////////////////

  jsp_fifo_ctrl u_ctrl (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .wr_event_i   (wr_event),
    .wr_data_i    (wr_byte),
    .rd_event_i   (rd_event),
    .wr_clr_o     (wr_clr),
    .rd_clr_o     (rd_clr),
    .fifo_rd_req_i(fifo_rd_req),
    .fifo_wr_req_i(fifo_wr_req),
    .pwdata_i     (PWDATA),
    .fifo_ack_o   (fifo_ack),
    .data_o       (data_o),
    .rx           (rx_if.ctrl),
    .tx           (tx_if.ctrl)
  );

  jsp_uart_regs u_regs (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .psel_i       (PSEL),
    .penable_i    (PENABLE),
    .pwrite_i     (PWRITE),
    .paddr_i      (PADDR),
    .pwdata_i     (PWDATA),
    .fifo_ack_i   (fifo_ack),
    .prdata_o     (PRDATA),
    .pready_o     (PREADY),
    .fifo_rd_req_o(fifo_rd_req),
    .fifo_wr_req_o(fifo_wr_req),
    .int_o        (int_o),
    .rx           (rx_if.regs),
    .tx           (tx_if.regs)
  );

  // No error responses
  assign PSLVERR = 1'b0;

endmodule

/* jsp_chk.sv */
// Bound protocol and status assertions for the JTAG serial port bridge top
`timescale 1ns/100ps

module jsp_chk (
  input logic       PCLK,
  input logic       PRESETn,
  input logic       psel_i,
  input logic       penable_i,
  input logic       pready_i,
  input logic       pslverr_i,
  input logic       int_i,
  input logic [3:0] ier_i,
  input logic [3:0] rx_cnt_i,
  input logic [3:0] tx_cnt_i
);

  // No error responses at all
  a_no_slverr: assert property (@(posedge PCLK) disable iff (!PRESETn) !pslverr_i)
    else $error("PSLVERR went high");

  // Occupancy never past the depth
  a_cnt_range: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (rx_cnt_i <= 4'd8) && (tx_cnt_i <= 4'd8))
    else $error("FIFO count above depth");

  // Interrupt fully masked by IER
  a_int_masked: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (ier_i == 4'h0) |-> !int_i)
    else $error("int_o high with IER clear");

  // Ready only inside an access phase
  a_ready_phase: assert property (@(posedge PCLK) disable iff (!PRESETn)
    pready_i |-> (psel_i && penable_i))
    else $error("PREADY outside access phase");

endmodule

bind jsp_apb_top jsp_chk u_chk (
  .PCLK     (PCLK),
  .PRESETn  (PRESETn),
  .psel_i   (PSEL),
  .penable_i(PENABLE),
  .pready_i (PREADY),
  .pslverr_i(PSLVERR),
  .int_i    (int_o),
  .ier_i    (u_regs.ier_q),
  .rx_cnt_i (rx_if.count),
  .tx_cnt_i (tx_if.count)
);

/* tb_jsp.sv */
// Directed testbench for the JTAG serial port bridge, APB and debug sides
`timescale 1ns/100ps

module tb_jsp;

  localparam int TIMEOUT_CYCLES = 20000;

  logic       tck_i;
  logic       PCLK;
  logic       PRESETn;
  logic [7:0] data_i;
  logic [7:0] data_o;
  logic       wr_strobe_i;
  logic       rd_strobe_i;
  logic [3:0] bytes_free_o;
  logic [3:0] bytes_available_o;
  logic       PSEL;
  logic       PENABLE;
  logic       PWRITE;
  logic [2:0] PADDR;
  logic [7:0] PWDATA;
  logic [7:0] PRDATA;
  logic       PREADY;
  logic       PSLVERR;
  logic       int_o;
  int         errors;
  int         cycles;

  jsp_apb_top u_jsp_apb_top (
    .tck_i            (tck_i),
    .PCLK             (PCLK),
    .PRESETn          (PRESETn),
    .data_i           (data_i),
    .data_o           (data_o),
    .wr_strobe_i      (wr_strobe_i),
    .rd_strobe_i      (rd_strobe_i),
    .bytes_free_o     (bytes_free_o),
    .bytes_available_o(bytes_available_o),
    .PSEL             (PSEL),
    .PENABLE          (PENABLE),
    .PWRITE           (PWRITE),
    .PADDR            (PADDR),
    .PWDATA           (PWDATA),
    .PRDATA           (PRDATA),
    .PREADY           (PREADY),
    .PSLVERR          (PSLVERR),
    .int_o            (int_o)
  );

  ////////////////////////////////////////////////////////////
  // Clocks and watchdog
  ////////////////////////////////////////////////////////////

  // 100 ns APB clock
  initial begin
    PCLK = 1'b0;
    forever #50 PCLK = ~PCLK;
  end

  // 170 ns debug clock with no fixed phase to PCLK
  initial begin
    tck_i = 1'b0;
    forever #85 tck_i = ~tck_i;
  end

  // Roughly four times the length of all tests
  initial begin
    cycles = 0;
    forever begin
      @(posedge PCLK);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: the DUT stopped responding before the tests ended");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected 0x%02h actual 0x%02h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // One APB transfer held in the access phase until PREADY
  task automatic apb_access(input logic wr, input logic [2:0] addr, input logic [7:0] wdata,
                            output logic [7:0] rdata);
    @(negedge PCLK);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = wr;
    PADDR   = addr;
    PWDATA  = wdata;
    @(negedge PCLK);
    PENABLE = 1'b1;
    while (PREADY !== 1'b1) @(negedge PCLK);
    rdata = PRDATA;
    @(negedge PCLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic apb_write(input logic [2:0] addr, input logic [7:0] wdata);
    logic [7:0] unused;
    apb_access(1'b1, addr, wdata, unused);
  endtask

  task automatic apb_read(input logic [2:0] addr, output logic [7:0] rdata);
    apb_access(1'b0, addr, 8'h00, rdata);
  endtask

  // Read and compare in one go
  task automatic read_expect(input string name, input logic [2:0] addr, input logic [7:0] exp);
    logic [7:0] val;
    apb_read(addr, val);
    check(name, exp, val);
  endtask

  task automatic wait_free(input logic [3:0] exp);
    while (bytes_free_o !== exp) @(negedge tck_i);
  endtask

  task automatic wait_avail(input logic [3:0] exp);
    while (bytes_available_o !== exp) @(negedge tck_i);
  endtask

  // Debug write that ends once the free count settles at exp_free
  task automatic dbg_write(input logic [7:0] b, input logic [3:0] exp_free);
    @(negedge tck_i);
    data_i      = b;
    wr_strobe_i = 1'b1;
    @(negedge tck_i);
    wr_strobe_i = 1'b0;
    wait_free(exp_free);
  endtask

  task automatic dbg_read(input logic [3:0] exp_avail);
    @(negedge tck_i);
    rd_strobe_i = 1'b1;
    @(negedge tck_i);
    rd_strobe_i = 1'b0;
    wait_avail(exp_avail);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic reset_values();
    read_expect("reset_ier", jsp_pkg::ADDR_IER, 8'h00);
    read_expect("reset_lcr", jsp_pkg::ADDR_LCR, 8'h00);
    read_expect("reset_scr", jsp_pkg::ADDR_SCR, 8'h00);
    read_expect("reset_mcr", jsp_pkg::ADDR_MCR, 8'h00);
    read_expect("reset_iir", jsp_pkg::ADDR_IIR_FCR, 8'h01);
    read_expect("reset_lsr", jsp_pkg::ADDR_LSR, 8'h60);
    read_expect("reset_msr", jsp_pkg::ADDR_MSR, 8'h0B);
    check("reset_int", 8'h00, {7'h0, int_o});
    check("reset_free", 8'h08, {4'h0, bytes_free_o});
    check("reset_avail", 8'h00, {4'h0, bytes_available_o});
  endtask

  task automatic register_file();
    logic [7:0] b;
    apb_write(jsp_pkg::ADDR_SCR, 8'hA5);
    read_expect("regs_scr", jsp_pkg::ADDR_SCR, 8'hA5);
    apb_write(jsp_pkg::ADDR_LCR, 8'h03);
    read_expect("regs_lcr", jsp_pkg::ADDR_LCR, 8'h03);
    // DLAB must keep one waiting rx byte in place
    b = 8'($urandom);
    dbg_write(b, 4'd7);
    apb_write(jsp_pkg::ADDR_LCR, 8'h80);
    apb_write(jsp_pkg::ADDR_IER, 8'h0F);
    read_expect("regs_ier_dlab", jsp_pkg::ADDR_IER, 8'h00);
    read_expect("regs_rbr_dlab", jsp_pkg::ADDR_RBR_THR, b);
    apb_write(jsp_pkg::ADDR_LCR, 8'h00);
    read_expect("regs_lsr_kept", jsp_pkg::ADDR_LSR, 8'h61);
    check("regs_free_kept", 8'h07, {4'h0, bytes_free_o});
    read_expect("regs_rbr_pop", jsp_pkg::ADDR_RBR_THR, b);
    wait_free(4'd8);
  endtask

  task automatic debug_to_apb();
    logic [7:0] q[$];
    logic [7:0] val;
    apb_write(jsp_pkg::ADDR_IER, 8'h01);
    for (int i = 0; i < 5; i++) begin
      q.push_back(8'($urandom));
      dbg_write(q[i], 4'(7 - i));
    end
    read_expect("d2a_iir", jsp_pkg::ADDR_IIR_FCR, 8'h04);
    for (int i = 0; i < 5; i++) begin
      check("d2a_int", 8'h01, {7'h0, int_o});
      apb_read(jsp_pkg::ADDR_LSR, val);
      check("d2a_lsr0", 8'h01, {7'h0, val[0]});
      read_expect("d2a_data", jsp_pkg::ADDR_RBR_THR, q[i]);
    end
    read_expect("d2a_lsr_end", jsp_pkg::ADDR_LSR, 8'h60);
    check("d2a_int_end", 8'h00, {7'h0, int_o});
    wait_free(4'd8);
  endtask

  task automatic apb_to_debug();
    logic [7:0] q[$];
    logic [7:0] exp;
    for (int i = 0; i < 6; i++) begin
      q.push_back(8'($urandom));
      apb_write(jsp_pkg::ADDR_RBR_THR, q[i]);
    end
    wait_avail(4'd6);
    @(negedge PCLK);
    check("a2d_first", q[0], data_o);
    // Last pop leaves an empty head behind
    for (int i = 0; i < 6; i++) begin
      dbg_read(4'(5 - i));
      @(negedge PCLK);
      exp = (i < 5) ? q[i + 1] : 8'h00;
      check("a2d_next", exp, data_o);
    end
  endtask

  task automatic full_and_flush();
    for (int i = 0; i < 9; i++) begin
      apb_write(jsp_pkg::ADDR_RBR_THR, 8'($urandom));
    end
    wait_avail(4'd8);
    read_expect("full_lsr", jsp_pkg::ADDR_LSR, 8'h00);
    apb_write(jsp_pkg::ADDR_IIR_FCR, 8'h04);
    wait_avail(4'd0);
    read_expect("flush_tx_lsr", jsp_pkg::ADDR_LSR, 8'h60);
    for (int i = 0; i < 8; i++) begin
      dbg_write(8'($urandom), 4'(7 - i));
    end
    // Event latency plus the count transfer, so an accepted ninth byte would show
    dbg_write(8'($urandom), 4'd0);
    repeat (16) @(negedge tck_i);
    check("full_free", 8'h00, {4'h0, bytes_free_o});
    apb_write(jsp_pkg::ADDR_IIR_FCR, 8'h02);
    wait_free(4'd8);
    read_expect("flush_rx_lsr", jsp_pkg::ADDR_LSR, 8'h60);
  endtask

  task automatic thr_interrupt();
    // Retire any THRE left from earlier writes
    apb_write(jsp_pkg::ADDR_IER, 8'h00);
    read_expect("thre_iir_pre", jsp_pkg::ADDR_IIR_FCR, 8'h02);
    read_expect("thre_iir_idle", jsp_pkg::ADDR_IIR_FCR, 8'h01);
    apb_write(jsp_pkg::ADDR_IER, 8'h02);
    check("thre_int_idle", 8'h00, {7'h0, int_o});
    apb_write(jsp_pkg::ADDR_RBR_THR, 8'($urandom));
    wait_avail(4'd1);
    // Clear the arm from the write so only the drain can raise it again
    read_expect("thre_iir_wr", jsp_pkg::ADDR_IIR_FCR, 8'h02);
    check("thre_int_wait", 8'h00, {7'h0, int_o});
    dbg_read(4'd0);
    @(negedge PCLK);
    check("thre_int_set", 8'h01, {7'h0, int_o});
    read_expect("thre_iir", jsp_pkg::ADDR_IIR_FCR, 8'h02);
    check("thre_int_clr", 8'h00, {7'h0, int_o});
    read_expect("thre_iir_done", jsp_pkg::ADDR_IIR_FCR, 8'h01);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    errors      = 0;
    void'($urandom(54));
    PRESETn     = 1'b0;
    data_i      = 8'h00;
    wr_strobe_i = 1'b0;
    rd_strobe_i = 1'b0;
    PSEL        = 1'b0;
    PENABLE     = 1'b0;
    PWRITE      = 1'b0;
    PADDR       = 3'd0;
    PWDATA      = 8'h00;
    repeat (10) @(posedge PCLK);
    @(negedge PCLK);
    PRESETn = 1'b1;
    repeat (2) @(negedge PCLK);

    reset_values();
    register_file();
    debug_to_apb();
    apb_to_debug();
    full_and_flush();
    thr_interrupt();

    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
jsp_pkg.sv
jsp_fifo_if.sv
jsp_byte_fifo.sv
jsp_toggle_sync.sv
jsp_count_sync.sv
jsp_fifo_ctrl.sv
jsp_uart_regs.sv
jsp_apb_top.sv
jsp_chk.sv
tb_jsp.sv

/* Makefile */
TOP := tb_jsp

obj_dir/V$(TOP): project.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f project.f

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) | tee sim.log
	@grep -q "Result: PASSED" sim.log && ! grep -q "Result: FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
